// File: rtl/sdram_cmd_pkg.sv
// SDRAM command codes and burst timing, imported by the sequencers, the arbiter, init and capture
`default_nettype none

package sdram_cmd_pkg;

    // bits are /CS /RAS /CAS /WE
    localparam logic [3:0] cmd_load_mode = 4'b0000;
    localparam logic [3:0] cmd_refresh   = 4'b0001;
    localparam logic [3:0] cmd_precharge = 4'b0010;
    localparam logic [3:0] cmd_active    = 4'b0011;
    localparam logic [3:0] cmd_read      = 4'b0101;
    localparam logic [3:0] cmd_nop       = 4'b0111;

    localparam int burst_len = 4;   // 16-bit beats per read
    localparam int cas_lat   = 2;

    // A12..A10 reserved, A9 burst write, A8..A7 normal op, A6..A4 CL, A3 sequential, A2..A0 BL
    localparam logic [12:0] mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_lat), 1'b0,
                                         3'($clog2(burst_len))};

endpackage

`default_nettype wire

// File: rtl/sdram_geom_pkg.sv
// SDRAM address geometry and the two views of the multiplexed address bus, imported where needed
`default_nettype none

package sdram_geom_pkg;

    localparam int row_w  = 13;
    localparam int col_w  = 9;
    localparam int bank_w = 2;

    // address bus as seen by a READ
    typedef struct packed {
        logic [1:0]     spare;      // A12..A11
        logic           auto_pre;   // A10, kept low, banks stay open
        logic [col_w:0] column;     // top bit zero on this part
    } sdram_col_t;

    // ACTIVE reads the bus as a row, READ as a column word
    typedef union packed {
        logic [row_w-1:0] row;
        sdram_col_t       col;
    } sdram_a_t;

endpackage

`default_nettype wire

// File: rtl/sdram_bank_seq.sv
// one bank's read sequencer, keeps the open row and requests the command bus for PRE, ACT and READ
`default_nettype none

module sdram_bank_seq #(
    parameter int aw = 22
) (
    input  wire                       clk,
    input  wire                       rst,

    input  wire  [aw-3:0]             addr,     // row and column inside the bank
    input  wire                       rd,
    output logic                      ack,
    output logic                      dst,
    output logic                      dok,
    output logic                      rdy,

    output logic                      dbusy,
    output logic                      dqm_busy,
    output logic                      post_act, // tRRD window after our ACT
    input  wire                       all_dbusy,
    input  wire                       all_dqm,
    input  wire                       all_act,

    output logic                      br,
    input  wire                       bg,
    output sdram_geom_pkg::sdram_a_t  sdram_a,
    output logic [3:0]                cmd
);
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;

    // one-hot ring, a precharge walks 0..3, an ACT jumps to 4, a READ jumps to 8
    localparam int st_idle    = 0;
    localparam int st_pre_act = 3;
    localparam int st_act     = st_pre_act + 1;
    localparam int st_pre_rd  = st_act + 3;   // tRCD
    localparam int st_read    = st_pre_rd + 1;
    localparam int st_dst     = st_read + 1;
    localparam int st_rdy     = st_dst + burst_len - 1;
    localparam int stw        = st_rdy + 1;

    logic [stw-1:0]   st, next_st, rot_st;
    logic [row_w-1:0] open_row;
    logic [row_w-1:0] addr_row;
    logic [col_w-1:0] addr_col;
    logic             prechd;
    logic             waiting;
    logic             row_hit;
    logic             blocked;
    logic             do_prech, do_act, do_read;
    logic [1:0]       last_act;

    assign addr_row = row_w'(addr[aw-3:col_w]);
    assign addr_col = addr[col_w-1:0];
    assign row_hit  = !prechd && open_row == addr_row;
    assign waiting  = st[st_idle] | st[st_pre_act] | st[st_pre_rd];

    assign ack      = st[st_read];
    assign dst      = st[st_dst];
    assign dok      = |st[st_rdy:st_dst];
    assign rdy      = st[st_rdy];
    // a READ from another bank now would put its burst on top of ours
    assign dbusy    = |st[st_rdy-2:st_read];
    assign dqm_busy = |st[st_dst+1:st_read]; // read mask leads data by two
    assign post_act = |last_act;

    // only ask for the bus when the command can go out right away
    always_comb begin
        blocked  = prechd ? all_act : (row_hit & (all_dbusy | all_dqm));
        br       = rd & waiting & !blocked;
        do_prech = br & bg & !prechd & !row_hit;
        do_act   = br & bg & prechd;
        do_read  = br & bg & row_hit;
    end

    always_comb begin
        rot_st  = {st[stw-2:0], st[stw-1]};
        next_st = st;
        if (!waiting) begin
            next_st = rot_st;           // fixed delays run free
        end else if (do_act && st[st_idle]) begin
            next_st = stw'(1) << st_act;
        end else if (do_read && st[st_idle]) begin
            next_st = stw'(1) << st_read;
        end else if (do_prech || do_act || do_read) begin
            next_st = rot_st;
        end
    end

    always_comb begin
        cmd     = cmd_nop;
        sdram_a = '0;                   // A10 low, single bank precharge
        if (do_prech) begin
            cmd = cmd_precharge;
        end
        if (do_act) begin
            cmd         = cmd_active;
            sdram_a.row = addr_row;
        end
        if (do_read) begin
            cmd                = cmd_read;
            sdram_a.col.column = {1'b0, addr_col};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= stw'(1);
            prechd   <= 1'b1;
            last_act <= '0;
        end else begin
            st       <= next_st;
            last_act <= {do_act, last_act[1]};
            if (do_act) begin
                prechd <= 1'b0;
            end
            if (do_prech) begin
                prechd <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_act) begin
            open_row <= addr_row;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sdram_bus_arbiter.sv
// shares the SDRAM command bus between banks round-robin and registers the pin outputs
`default_nettype none

module sdram_bus_arbiter #(
    parameter int n_banks = 4
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          init_done,

    input  wire  [n_banks-1:0]                           br,
    output logic [n_banks-1:0]                           bg,
    input  wire  [n_banks*4-1:0]                         bank_cmd,
    input  wire  sdram_geom_pkg::sdram_a_t [n_banks-1:0] bank_a,

    input  wire  [n_banks-1:0]                           dbusy,
    input  wire  [n_banks-1:0]                           dqm_busy,
    input  wire  [n_banks-1:0]                           post_act,
    output logic                                         all_dbusy,
    output logic                                         all_dqm,
    output logic                                         all_act,

    input  wire  [3:0]                                   init_cmd,
    input  wire  [sdram_geom_pkg::row_w-1:0]             init_a,

    output logic [3:0]                                   sdram_cmd,
    output logic [sdram_geom_pkg::bank_w-1:0]            sdram_ba,
    output sdram_geom_pkg::sdram_a_t                     sdram_a
);
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;

    logic [bank_w-1:0] ptr;     // highest priority this cycle
    logic [bank_w-1:0] win;
    logic              any_req;
    logic              grant;

    assign all_dbusy = |dbusy;
    assign all_dqm   = |dqm_busy;
    assign all_act   = |post_act;

    // first requester at or after ptr
    always_comb begin
        int idx;
        win     = '0;
        any_req = 1'b0;
        for (int i = 0; i < n_banks; i++) begin
            idx = (int'(ptr) + i) % n_banks;
            if (!any_req && br[idx]) begin
                any_req = 1'b1;
                win     = bank_w'(idx);
            end
        end
        grant = init_done & any_req;
    end

    assign bg = grant ? (n_banks'(1) << win) : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr       <= '0;
            sdram_cmd <= cmd_nop;
            sdram_ba  <= '0;
            sdram_a   <= '0;
        end else if (!init_done) begin
            sdram_cmd <= init_cmd;      // banks are held off until init ends
            sdram_ba  <= '0;
            sdram_a   <= init_a;
        end else if (grant) begin
            sdram_cmd <= bank_cmd[win*4 +: 4];
            sdram_ba  <= win;
            sdram_a   <= bank_a[win];
            ptr       <= (int'(win) == n_banks - 1) ? '0 : win + 1'b1;
        end else begin
            sdram_cmd <= cmd_nop;       // ba and A just hold
        end
    end

endmodule

`default_nettype wire

// File: rtl/sdram_init_seq.sv
// power-up sequence for the SDRAM, drives the pins through the arbiter until init_done rises
`default_nettype none

module sdram_init_seq #(
    parameter int init_refresh = 8
) (
    input  wire                              clk,
    input  wire                              rst,
    output logic [3:0]                       init_cmd,
    output logic [sdram_geom_pkg::row_w-1:0] init_a,
    output logic                             init_done
);
    import sdram_cmd_pkg::*;

    localparam logic [1:0] ph_pre  = 2'd0;
    localparam logic [1:0] ph_ref  = 2'd1;
    localparam logic [1:0] ph_lmr  = 2'd2;
    localparam logic [1:0] ph_wait = 2'd3;
    localparam int         cnt_w   = $clog2(init_refresh + 1);
    localparam logic [2:0] ref_gap = 3'd7;  // refreshes 8 cycles apart

    logic [1:0]       phase;
    logic [2:0]       gap;
    logic [cnt_w-1:0] ref_cnt;
    logic             ref_now;

    assign ref_now = !init_done && phase == ph_ref && gap == '0 &&
                     ref_cnt != cnt_w'(init_refresh);

    always_comb begin
        init_cmd = cmd_nop;
        init_a   = '0;
        if (!init_done) begin
            case (phase)
                ph_pre: begin
                    init_cmd   = cmd_precharge;
                    init_a[10] = 1'b1;          // all banks
                end
                ph_lmr: begin
                    init_cmd = cmd_load_mode;
                    init_a   = mode_word;
                end
                default: begin
                    if (ref_now) begin
                        init_cmd = cmd_refresh;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= ph_pre;
            gap       <= '0;
            ref_cnt   <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            case (phase)
                ph_pre: begin
                    phase <= ph_ref;
                    gap   <= ref_gap;           // also covers tRP
                end
                ph_ref: begin
                    if (gap != '0) begin
                        gap <= gap - 1'b1;
                    end else if (ref_now) begin
                        ref_cnt <= ref_cnt + 1'b1;
                        gap     <= ref_gap;
                    end else begin
                        phase <= ph_lmr;
                    end
                end
                ph_lmr: begin
                    phase <= ph_wait;
                    gap   <= 3'd2;              // three NOPs after the mode load
                end
                default: begin
                    if (gap == '0) begin
                        init_done <= 1'b1;
                    end else begin
                        gap <= gap - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/sdram_read_capture.sv
// collects the four beats of each read burst from DQ into one 64-bit word for the client
`default_nettype none

module sdram_read_capture #(
    parameter int n_banks = 4
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire  [n_banks-1:0]                dok,
    input  wire  [n_banks-1:0]                rdy,
    input  wire  [15:0]                       dq,
    output logic [63:0]                       rdata,
    output logic                              rvalid,
    output logic [sdram_geom_pkg::bank_w-1:0] rbank
);
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;

    localparam int beat_w = 16;

    logic                            dok_d;   // lines up with the beat on dq
    logic [n_banks-1:0]              rdy_d;
    logic [(burst_len-1)*beat_w-1:0] beats;   // all but the last beat

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dok_d <= 1'b0;
            rdy_d <= '0;
        end else begin
            dok_d <= |dok;
            rdy_d <= rdy;
        end
    end

    // first beat drifts down to the lowest lane
    always_ff @(posedge clk) begin
        if (dok_d) begin
            beats <= {dq, beats[(burst_len-1)*beat_w-1:beat_w]};
        end
    end

    // last beat is still on dq when rvalid is up
    assign rdata  = {dq, beats};
    assign rvalid = |rdy_d;

    always_comb begin
        rbank = '0;
        for (int b = 0; b < n_banks; b++) begin
            if (rdy_d[b]) begin
                rbank = bank_w'(b);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sdram_rd_ctrl.sv
// read-only multi-bank SDRAM controller, top level the client and the SDRAM pins attach to
`default_nettype none

module sdram_rd_ctrl #(
    parameter int aw           = 22,
    parameter int n_banks      = 4,
    parameter int init_refresh = 8
) (
    input  wire                               clk,
    input  wire                               rst,

    input  wire  [n_banks-1:0]                rd,
    input  wire  [n_banks*(aw-2)-1:0]         addr,   // one in-bank address per bank
    output logic [n_banks-1:0]                ack,
    output logic [n_banks-1:0]                rdy,
    output logic [63:0]                       rdata,
    output logic                              rvalid,
    output logic [sdram_geom_pkg::bank_w-1:0] rbank,

    output logic [3:0]                        sdram_cmd,
    output logic [sdram_geom_pkg::bank_w-1:0] sdram_ba,
    output sdram_geom_pkg::sdram_a_t          sdram_a,
    input  wire  [15:0]                       sdram_dq
);
    import sdram_geom_pkg::*;

    logic [n_banks-1:0]        br, bg;
    logic [n_banks-1:0]        dok;
    logic [n_banks-1:0]        dbusy, dqm_busy, post_act;
    logic                      all_dbusy, all_dqm, all_act;
    logic [n_banks*4-1:0]      seq_cmd;
    sdram_a_t [n_banks-1:0]    seq_a;
    logic [3:0]                init_cmd;
    logic [row_w-1:0]          init_a;
    logic                      init_done;

    for (genvar b = 0; b < n_banks; b++) begin : g_bank
        sdram_bank_seq #(
            .aw(aw)
        ) seq_i (
            .clk      (clk),
            .rst      (rst),
            .addr     (addr[b*(aw-2) +: aw-2]),
            .rd       (rd[b]),
            .ack      (ack[b]),
            .dst      (),
            .dok      (dok[b]),
            .rdy      (rdy[b]),
            .dbusy    (dbusy[b]),
            .dqm_busy (dqm_busy[b]),
            .post_act (post_act[b]),
            .all_dbusy(all_dbusy),
            .all_dqm  (all_dqm),
            .all_act  (all_act),
            .br       (br[b]),
            .bg       (bg[b]),
            .sdram_a  (seq_a[b]),
            .cmd      (seq_cmd[b*4 +: 4])
        );
    end

    sdram_bus_arbiter #(
        .n_banks(n_banks)
    ) arb_i (
        .clk      (clk),
        .rst      (rst),
        .init_done(init_done),
        .br       (br),
        .bg       (bg),
        .bank_cmd (seq_cmd),
        .bank_a   (seq_a),
        .dbusy    (dbusy),
        .dqm_busy (dqm_busy),
        .post_act (post_act),
        .all_dbusy(all_dbusy),
        .all_dqm  (all_dqm),
        .all_act  (all_act),
        .init_cmd (init_cmd),
        .init_a   (init_a),
        .sdram_cmd(sdram_cmd),
        .sdram_ba (sdram_ba),
        .sdram_a  (sdram_a)
    );

    sdram_init_seq #(
        .init_refresh(init_refresh)
    ) init_i (
        .clk      (clk),
        .rst      (rst),
        .init_cmd (init_cmd),
        .init_a   (init_a),
        .init_done(init_done)
    );

    sdram_read_capture #(
        .n_banks(n_banks)
    ) cap_i (
        .clk   (clk),
        .rst   (rst),
        .dok   (dok),
        .rdy   (rdy),
        .dq    (sdram_dq),
        .rdata (rdata),
        .rvalid(rvalid),
        .rbank (rbank)
    );

endmodule

`default_nettype wire

// File: verification/sdram_model.sv
// behavioral SDRAM for the testbench, tracks open rows and answers READ with a CL 2 patterned burst
`default_nettype none

module sdram_model (
    input  wire                               clk,
    input  wire                               rst,
    input  wire  [3:0]                        cmd,
    input  wire  [sdram_geom_pkg::bank_w-1:0] ba,
    input  wire  sdram_geom_pkg::sdram_a_t    a,
    output logic [15:0]                       dq,
    output logic                              bad_cmd   // sticky, illegal command order seen
);
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;

    logic [row_w-1:0] open_row [4];
    logic [3:0]       is_open;
    logic             pend;         // READ taken, first beat goes out on the next edge
    logic [1:0]       pend_ba, cur_ba;
    logic [row_w-1:0] pend_row, cur_row;
    logic [col_w-1:0] pend_col, cur_col;
    int               beat;         // beat now on dq, -1 when idle

    // each beat is (row*31 + col*7 + beat), top nibble xored with {bank, beat}
    function automatic logic [15:0] beat_data(input logic [1:0] bank, input logic [12:0] row,
                                              input logic [8:0] col, input int idx);
        logic [15:0] mix;
        mix = 16'(int'(row) * 31 + int'(col) * 7 + idx);
        return mix ^ {bank, 2'(idx), 12'h000};
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            is_open <= '0;
            pend    <= 1'b0;
            beat    <= -1;
            dq      <= '0;
            bad_cmd <= 1'b0;
        end else begin
            pend <= 1'b0;
            if (pend) begin
                cur_ba  <= pend_ba;
                cur_row <= pend_row;
                cur_col <= pend_col;
                beat    <= 0;
                dq      <= beat_data(pend_ba, pend_row, pend_col, 0);
            end else if (beat >= 0 && beat < burst_len - 1) begin
                beat <= beat + 1;
                dq   <= beat_data(cur_ba, cur_row, cur_col, beat + 1);
            end else begin
                beat <= -1;
                dq   <= '0;
            end

            case (cmd)
                cmd_active: begin
                    if (is_open[ba]) begin
                        bad_cmd <= 1'b1;        // ACT on an open bank
                    end
                    is_open[ba]  <= 1'b1;
                    open_row[ba] <= a.row;
                end
                cmd_precharge: begin
                    if (a.row[10]) begin
                        is_open <= '0;          // all banks
                    end else begin
                        is_open[ba] <= 1'b0;
                    end
                end
                cmd_read: begin
                    if (!is_open[ba] || a.col.auto_pre) begin
                        bad_cmd <= 1'b1;
                    end
                    pend     <= 1'b1;
                    pend_ba  <= ba;
                    pend_row <= open_row[ba];
                    pend_col <= a.col.column[col_w-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/sdram_rd_tb.sv
// testbench for the SDRAM read controller, a directed request table and then LCG traffic on 4 banks
`default_nettype none

module sdram_rd_tb;
    import sdram_cmd_pkg::*;
    import sdram_geom_pkg::*;

    localparam int aw       = 22;
    localparam int n_banks  = 4;
    localparam int n_ref    = 8;
    localparam int n_dir    = 9;
    localparam int n_rand   = 12;                 // reads per bank in the LCG phase
    localparam int total    = n_dir + n_banks * n_rand;
    localparam int cls_hit  = 0;
    localparam int cls_miss = 1;
    localparam int cls_conf = 2;
    localparam logic [12:0] exp_mode = 13'h022;   // CL 2, sequential, BL 4

    // {class, bank, row, col}
    localparam logic [23:0] dir_tab [n_dir] = '{
        {2'd1, 2'd0, 11'd5,    9'd16},
        {2'd0, 2'd0, 11'd5,    9'd40},
        {2'd2, 2'd0, 11'd9,    9'd3},
        {2'd1, 2'd2, 11'd100,  9'd500},
        {2'd0, 2'd2, 11'd100,  9'd0},
        {2'd1, 2'd1, 11'd2047, 9'd511},
        {2'd2, 2'd2, 11'd7,    9'd8},
        {2'd0, 2'd1, 11'd2047, 9'd1},
        {2'd0, 2'd0, 11'd9,    9'd4}
    };

    logic                      clk = 1'b0;
    logic                      rst;
    logic [n_banks-1:0]        rd;
    logic [n_banks*(aw-2)-1:0] addr;
    logic [n_banks-1:0]        ack, rdy;
    logic [63:0]               rdata;
    logic                      rvalid;
    logic [1:0]                rbank;
    logic [3:0]                sdram_cmd;
    logic [1:0]                sdram_ba;
    sdram_a_t                  sdram_a;
    logic [15:0]               sdram_dq;
    logic                      bad_cmd;

    logic [18:0] cmd_log [$];   // {ba, cmd, A} of every non-NOP pin command
    logic [65:0] pend_q [$];    // {bank, expected word}
    int          cyc = 0;
    int          last_act = -100;
    int          last_rd = -100;
    int          n_pre_all = 0;
    int          n_ref_seen = 0;
    int          n_lmr = 0;
    int          ack_cnt = 0;
    int          rvalid_cnt = 0;
    bit          init_seen = 1'b0;
    logic [n_banks-1:0] rdy_prev = '0;   // rdy one cycle back
    logic [31:0] seed;

    always #4 clk = ~clk;

    sdram_rd_ctrl #(
        .aw          (aw),
        .n_banks     (n_banks),
        .init_refresh(n_ref)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .rd       (rd),
        .addr     (addr),
        .ack      (ack),
        .rdy      (rdy),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rbank    (rbank),
        .sdram_cmd(sdram_cmd),
        .sdram_ba (sdram_ba),
        .sdram_a  (sdram_a),
        .sdram_dq (sdram_dq)
    );

    sdram_model mem_i (
        .clk    (clk),
        .rst    (rst),
        .cmd    (sdram_cmd),
        .ba     (sdram_ba),
        .a      (sdram_a),
        .dq     (sdram_dq),
        .bad_cmd(bad_cmd)
    );

    task automatic abort_run(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // data pattern the SDRAM model documents for each beat
    function automatic logic [15:0] beat_value(input logic [1:0] bank, input logic [12:0] row,
                                               input logic [8:0] col, input int idx);
        logic [15:0] mix;
        mix = 16'(int'(row) * 31 + int'(col) * 7 + idx);
        return mix ^ {bank, 2'(idx), 12'h000};
    endfunction

    function automatic logic [63:0] expected_word(input logic [1:0] bank, input logic [10:0] row,
                                                  input logic [8:0] col);
        logic [63:0] w;
        for (int i = 0; i < 4; i++) begin
            w[i*16 +: 16] = beat_value(bank, 13'(row), col, i);   // first beat lowest
        end
        return w;
    endfunction

    // pin monitor, init counts and command spacing
    always @(posedge clk) begin
        if (!rst) begin
            cyc++;
            if (sdram_cmd != cmd_nop) begin
                cmd_log.push_back({sdram_ba, sdram_cmd, sdram_a});
            end
            if (!init_seen) begin
                if (sdram_cmd == cmd_precharge && sdram_a.row[10]) begin
                    n_pre_all++;
                end
                if (sdram_cmd == cmd_refresh) begin
                    n_ref_seen++;
                end
                if (sdram_cmd == cmd_load_mode) begin
                    n_lmr++;
                    check_eq(sdram_a.row, exp_mode, "load mode word");
                end
            end
            if (sdram_cmd == cmd_active || sdram_cmd == cmd_read) begin
                if (!init_seen) begin
                    check_eq(n_pre_all, 1, "precharge-all commands in init");
                    check_eq(n_ref_seen, n_ref, "refresh commands in init");
                    check_eq(n_lmr, 1, "load mode commands in init");
                end
                init_seen = 1'b1;
            end
            if (sdram_cmd == cmd_active) begin
                check_eq(cyc - last_act < 2, 0, "ACT closer than tRRD to the previous ACT");
                last_act = cyc;
            end
            if (sdram_cmd == cmd_read) begin
                check_eq(cyc - last_rd < 4, 0, "READ bursts overlap on DQ");
                last_rd = cyc;
            end
        end
    end

    // acks and returned words against the outstanding reads
    always @(posedge clk) begin : resp_check
        int found;
        if (!rst) begin
            if ((ack & ~rd) != '0) begin
                abort_run("ack came for a bank with no pending read");
            end
            for (int b = 0; b < n_banks; b++) begin
                if (ack[b]) begin
                    ack_cnt++;
                end
            end
            check_eq(rvalid, rdy_prev != '0, "rvalid one cycle after rdy");
            if (rvalid) begin
                check_eq(rdy_prev, n_banks'(1) << rbank, "bank of the rdy pulse before rvalid");
                found = -1;
                for (int i = 0; i < pend_q.size(); i++) begin
                    if (found < 0 && pend_q[i][65:64] == rbank) begin
                        found = i;
                    end
                end
                if (found < 0) begin
                    abort_run("rvalid for a bank with no read outstanding");
                end else begin
                    check_eq(rdata, pend_q[found][63:0], "read data");
                    pend_q.delete(found);
                    rvalid_cnt++;
                end
            end
            rdy_prev = rdy;
        end
    end

    task automatic wait_init();
        int guard;
        guard = 0;
        while (n_lmr == 0) begin
            @(posedge clk);
            guard++;
            if (guard > 300) begin
                abort_run("init sequence never issued a load mode");
            end
        end
    endtask

    task automatic wait_ack(input int b);
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
            if (guard > 400) begin
                abort_run("read request was never acknowledged");
            end
        end while (!ack[b]);
        rd[b] <= 1'b0;
    endtask

    task automatic wait_rvalid(input int target);
        int guard;
        guard = 0;
        while (rvalid_cnt < target) begin
            @(posedge clk);
            guard++;
            if (guard > 50) begin
                abort_run("read data never came back");
            end
        end
    endtask

    // the commands on this bank must match the request class
    task automatic check_class(input int b, input logic [10:0] row, input logic [8:0] col,
                               input int cls);
        logic [18:0] seen [$];
        int          n;
        for (int i = 0; i < cmd_log.size(); i++) begin
            if (cmd_log[i][18:17] == 2'(b)) begin
                seen.push_back(cmd_log[i]);
            end
        end
        n = cls + 1;
        check_eq(seen.size(), n, "commands issued for this read");
        if (cls == cls_conf) begin
            check_eq(seen[0][16:13], cmd_precharge, "command before ACT");
        end
        if (cls == cls_miss || cls == cls_conf) begin
            check_eq(seen[n-2][16:13], cmd_active, "command before READ");
            check_eq(seen[n-2][12:0], 13'(row), "ACT row");
        end
        check_eq(seen[n-1][16:13], cmd_read, "last command");
        check_eq(seen[n-1][12:0], 13'(col), "READ column word");   // A10 low too
    endtask

    task automatic run_directed(input int idx);
        logic [23:0] ent;
        int          b;
        int          target;
        ent    = dir_tab[idx];
        b      = int'(ent[21:20]);
        target = rvalid_cnt + 1;
        cmd_log.delete();
        @(posedge clk);
        rd[b]                  <= 1'b1;
        addr[b*(aw-2) +: aw-2] <= ent[19:0];
        pend_q.push_back({ent[21:20], expected_word(ent[21:20], ent[19:9], ent[8:0])});
        wait_ack(b);
        wait_rvalid(target);
        check_class(b, ent[19:9], ent[8:0], int'(ent[23:22]));
    endtask

    task automatic run_random();
        int          sent [n_banks];
        int          guard;
        int          target;
        logic [10:0] row;
        logic [8:0]  col;
        guard  = 0;
        target = rvalid_cnt + n_banks * n_rand;
        for (int b = 0; b < n_banks; b++) begin
            sent[b] = 0;
        end
        while (rvalid_cnt < target) begin
            @(posedge clk);
            guard++;
            if (guard > 5000) begin
                abort_run("concurrent reads did not finish in time");
            end
            for (int b = 0; b < n_banks; b++) begin
                if (rd[b]) begin
                    if (ack[b]) begin
                        rd[b] <= 1'b0;
                    end
                end else if (sent[b] < n_rand) begin
                    seed = lcg_next(seed);
                    row  = 11'(seed[17:16]) * 11'd300;   // few rows, hits and conflicts mix
                    col  = seed[30:22];
                    rd[b]                  <= 1'b1;
                    addr[b*(aw-2) +: aw-2] <= {row, col};
                    pend_q.push_back({2'(b), expected_word(2'(b), row, col)});
                    sent[b]++;
                end
            end
        end
    endtask

    initial begin
        rst  = 1'b1;
        rd   = '0;
        addr = '0;
        seed = 32'd98618;
        repeat (2) @(posedge clk);
        check_eq(sdram_cmd, cmd_nop, "pin command in reset");
        check_eq({sdram_ba, ack, rdy, rvalid}, '0, "outputs in reset");
        rst <= 1'b0;
        wait_init();
        for (int i = 0; i < n_dir; i++) begin
            run_directed(i);
        end
        run_random();
        repeat (20) @(posedge clk);   // room for a stray ack or rvalid
        if (ack_cnt == total && rvalid_cnt == total && pend_q.size() == 0 && !bad_cmd) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("ack or rvalid count is off, or the SDRAM model saw an illegal command");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/sdram_cmd_pkg.sv
rtl/sdram_geom_pkg.sv
rtl/sdram_bank_seq.sv
rtl/sdram_bus_arbiter.sv
rtl/sdram_init_seq.sv
rtl/sdram_read_capture.sv
rtl/sdram_rd_ctrl.sv
verification/sdram_model.sv
verification/sdram_rd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the SDRAM read controller testbench with Verilator, run it, and check for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module sdram_rd_tb -o sdram_rd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sdram_rd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
